// File: source/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // main control states.
    typedef enum logic [2:0] {
        FETCH     = 3'd0,
        DECODE    = 3'd1,
        EXECUTE   = 3'd2,
        MEMORY    = 3'd3,
        WRITEBACK = 3'd4
    } cpu_state_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_NOR  = 4'd5,
        ALU_OR   = 4'd6,
        ALU_XOR  = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_LUI  = 4'd11
    } alu_op_t;

    typedef struct packed {
        logic        we;
        logic [31:0] addr;
        logic [31:0] wdata;
    } mem_req_t;

    typedef struct packed {
        alu_op_t     alu_op;
        logic        src1_is_pc;
        logic        src2_is_imm;
        logic        res_from_mem;
        logic        mem_we;
        logic        gr_we;
        logic [4:0]  dest;
        logic        src_reg_is_rd;
        logic        is_branch;
        logic        is_cond_branch;
        logic        branch_on_eq;
        logic        is_jirl;
        logic        illegal;
    } ctrl_t;

    // one retired register write.
    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  wnum;
        logic [31:0] wdata;
    } wb_trace_t;

endpackage

`default_nettype wire

// File: source/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder import cpu_pkg::*; (
    input  logic [31:0] inst_word,
    output ctrl_t       ctrl,
    output logic [31:0] imm,
    output logic [4:0]  raddr1,
    output logic [4:0]  raddr2
);

    logic [4:0] rd;
    logic [4:0] rj;
    logic [4:0] rk;
    logic       is_3r;
    logic       is_shift;
    logic       inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic       inst_nor, inst_and, inst_or, inst_xor;
    logic       inst_slli_w, inst_srli_w, inst_srai_w;
    logic       inst_addi_w, inst_lu12i_w, inst_ld_w, inst_st_w;
    logic       inst_jirl, inst_b, inst_bl, inst_beq, inst_bne;
    logic       any_alu_rr;
    logic       any_shift;

    assign rd = inst_word[4:0];
    assign rj = inst_word[9:5];
    assign rk = inst_word[14:10];

    // 3r and shift groups share the upper opcode bits.
    assign is_3r    = (inst_word[31:20] == 12'h001);
    assign is_shift = (inst_word[31:20] == 12'h004);

    assign inst_add_w   = is_3r && (inst_word[19:15] == 5'h00);
    assign inst_sub_w   = is_3r && (inst_word[19:15] == 5'h02);
    assign inst_slt     = is_3r && (inst_word[19:15] == 5'h04);
    assign inst_sltu    = is_3r && (inst_word[19:15] == 5'h05);
    assign inst_nor     = is_3r && (inst_word[19:15] == 5'h08);
    assign inst_and     = is_3r && (inst_word[19:15] == 5'h09);
    assign inst_or      = is_3r && (inst_word[19:15] == 5'h0a);
    assign inst_xor     = is_3r && (inst_word[19:15] == 5'h0b);
    assign inst_slli_w  = is_shift && (inst_word[19:15] == 5'h01);
    assign inst_srli_w  = is_shift && (inst_word[19:15] == 5'h09);
    assign inst_srai_w  = is_shift && (inst_word[19:15] == 5'h11);
    assign inst_addi_w  = (inst_word[31:22] == 10'h00a);
    assign inst_ld_w    = (inst_word[31:22] == 10'h0a2);
    assign inst_st_w    = (inst_word[31:22] == 10'h0a6);
    assign inst_lu12i_w = (inst_word[31:25] == 7'b0001010);
    assign inst_jirl    = (inst_word[31:26] == 6'h13);
    assign inst_b       = (inst_word[31:26] == 6'h14);
    assign inst_bl      = (inst_word[31:26] == 6'h15);
    assign inst_beq     = (inst_word[31:26] == 6'h16);
    assign inst_bne     = (inst_word[31:26] == 6'h17);

    assign any_alu_rr = inst_add_w | inst_sub_w | inst_slt | inst_sltu
                      | inst_nor | inst_and | inst_or | inst_xor;
    assign any_shift  = inst_slli_w | inst_srli_w | inst_srai_w;

    always_comb begin
        ctrl = '0;
        ctrl.alu_op = ALU_ADD;
        if (inst_sub_w)   ctrl.alu_op = ALU_SUB;
        if (inst_slt)     ctrl.alu_op = ALU_SLT;
        if (inst_sltu)    ctrl.alu_op = ALU_SLTU;
        if (inst_and)     ctrl.alu_op = ALU_AND;
        if (inst_nor)     ctrl.alu_op = ALU_NOR;
        if (inst_or)      ctrl.alu_op = ALU_OR;
        if (inst_xor)     ctrl.alu_op = ALU_XOR;
        if (inst_slli_w)  ctrl.alu_op = ALU_SLL;
        if (inst_srli_w)  ctrl.alu_op = ALU_SRL;
        if (inst_srai_w)  ctrl.alu_op = ALU_SRA;
        if (inst_lu12i_w) ctrl.alu_op = ALU_LUI;

        // link writes use pc as the first operand.
        ctrl.src1_is_pc     = inst_jirl | inst_bl;
        ctrl.src2_is_imm    = any_shift | inst_addi_w | inst_ld_w | inst_st_w | inst_lu12i_w;
        ctrl.res_from_mem   = inst_ld_w;
        ctrl.mem_we         = inst_st_w;
        ctrl.gr_we          = any_alu_rr | any_shift | inst_addi_w | inst_lu12i_w
                            | inst_ld_w | inst_jirl | inst_bl;
        ctrl.dest           = inst_bl ? 5'd1 : rd;
        ctrl.src_reg_is_rd  = inst_beq | inst_bne | inst_st_w;
        ctrl.is_branch      = inst_jirl | inst_b | inst_bl | inst_beq | inst_bne;
        ctrl.is_cond_branch = inst_beq | inst_bne;
        ctrl.branch_on_eq   = inst_beq;
        ctrl.is_jirl        = inst_jirl;
        ctrl.illegal        = ~(any_alu_rr | any_shift | inst_addi_w | inst_lu12i_w
                              | inst_ld_w | inst_st_w | ctrl.is_branch);
    end

    always_comb begin
        imm = '0;
        if (any_shift)
            imm = {27'b0, inst_word[14:10]};
        else if (inst_addi_w || inst_ld_w || inst_st_w)
            imm = {{20{inst_word[21]}}, inst_word[21:10]};
        else if (inst_lu12i_w)
            imm = {inst_word[24:5], 12'b0};
        else if (inst_jirl || inst_beq || inst_bne)
            imm = {{14{inst_word[25]}}, inst_word[25:10], 2'b0};
        else if (inst_b || inst_bl)
            imm = {{4{inst_word[9]}}, inst_word[9:0], inst_word[25:10], 2'b0};
    end

    assign raddr1 = rj;
    assign raddr2 = ctrl.src_reg_is_rd ? rd : rk;

endmodule

`default_nettype wire

// File: source/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic        clk,
    input  logic [4:0]  raddr1,
    output logic [31:0] rdata1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata2,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);

    logic [31:0] regs [0:31];

    // r0 is never written.
    always_ff @(posedge clk) begin
        if (we && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

endmodule

`default_nettype wire

// File: source/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import cpu_pkg::*; (
    input  alu_op_t     op,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic [31:0] result
);

    logic [4:0]  shamt;
    logic [31:0] diff;

    assign shamt = b[4:0];
    assign diff  = a - b;

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = diff;
            ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: result = {31'b0, a < b};
            ALU_AND:  result = a & b;
            ALU_NOR:  result = ~(a | b);
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_SLL:  result = a << shamt;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $unsigned($signed(a) >>> shamt);
            // immediate arrives already shifted.
            ALU_LUI:  result = b;
            default:  result = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

// File: source/cycle_control.sv
`timescale 1ns/1ps
`default_nettype none

module cycle_control import cpu_pkg::*; #(
    parameter logic [31:0] reset_pc = 32'h1c00_0000
) (
    input  logic        clk,
    input  logic        reset,
    output logic        inst_req,
    output logic [31:0] inst_addr,
    input  logic        inst_ack,
    input  logic [31:0] inst_rdata,
    output logic        data_req,
    output mem_req_t    data_out,
    input  logic        data_ack,
    input  logic [31:0] data_rdata,
    output logic [31:0] inst_word,
    input  ctrl_t       ctrl,
    input  logic [31:0] imm,
    input  logic [31:0] rs1_data,
    input  logic [31:0] rs2_data,
    output alu_op_t     alu_op,
    output logic [31:0] alu_a,
    output logic [31:0] alu_b,
    input  logic [31:0] alu_result,
    output logic        rf_we,
    output logic [4:0]  rf_waddr,
    output logic [31:0] rf_wdata,
    output logic        wb_valid,
    output wb_trace_t   trace
);

    cpu_state_t  state;
    logic [31:0] pc;
    logic [31:0] cur_pc;
    logic [31:0] ir;
    logic [31:0] rj_val;
    logic [31:0] rkd_val;
    logic [31:0] result_q;
    logic        ack_seen;
    logic        inst_done;
    logic        data_done;
    logic        branch_taken;
    logic [31:0] branch_target;
    logic        to_fetch;

    assign inst_done = inst_req & inst_ack;
    assign data_done = data_req & data_ack;

    // branches resolve on the register file outputs during decode.
    assign branch_taken  = ctrl.is_branch &&
                           (!ctrl.is_cond_branch ||
                            ((rs1_data == rs2_data) == ctrl.branch_on_eq));
    assign branch_target = (ctrl.is_jirl ? rs1_data : pc) + imm;
    assign to_fetch      = ctrl.illegal || (ctrl.is_branch && !ctrl.gr_we);

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= FETCH;
            pc       <= reset_pc;
            inst_req <= 1'b0;
            data_req <= 1'b0;
            ack_seen <= 1'b0;
            wb_valid <= 1'b0;
        end else begin
            case (state)
                FETCH: begin
                    if (!inst_req && !ack_seen) begin
                        inst_req <= 1'b1;
                    end else if (inst_done) begin
                        inst_req <= 1'b0;
                        ack_seen <= 1'b1;
                    end else if (ack_seen && !inst_ack) begin
                        ack_seen <= 1'b0;
                        state    <= DECODE;
                    end
                end
                DECODE: begin
                    pc    <= branch_taken ? branch_target : pc + 32'd4;
                    state <= to_fetch ? FETCH : EXECUTE;
                end
                EXECUTE: begin
                    if (ctrl.res_from_mem || ctrl.mem_we) begin
                        state <= MEMORY;
                    end else begin
                        state    <= WRITEBACK;
                        wb_valid <= 1'b1;
                    end
                end
                MEMORY: begin
                    if (!data_req && !ack_seen) begin
                        data_req <= 1'b1;
                    end else if (data_done) begin
                        data_req <= 1'b0;
                        ack_seen <= 1'b1;
                    end else if (ack_seen && !data_ack) begin
                        ack_seen <= 1'b0;
                        if (ctrl.mem_we) begin
                            state <= FETCH;
                        end else begin
                            state    <= WRITEBACK;
                            wb_valid <= 1'b1;
                        end
                    end
                end
                WRITEBACK: begin
                    wb_valid <= 1'b0;
                    state    <= FETCH;
                end
                default: state <= FETCH;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == FETCH && inst_done) begin
            ir <= inst_rdata;
        end
        if (state == DECODE) begin
            cur_pc  <= pc;
            rj_val  <= rs1_data;
            rkd_val <= rs2_data;
        end
        if (state == EXECUTE) begin
            result_q       <= alu_result;
            data_out.we    <= ctrl.mem_we;
            data_out.addr  <= alu_result;
            data_out.wdata <= rkd_val;
        end
        if (state == MEMORY && data_done && ctrl.res_from_mem) begin
            result_q <= data_rdata;
        end
    end

    assign inst_addr = pc;
    assign inst_word = ir;

    // link writes add 4 to the instruction pc.
    assign alu_op = ctrl.alu_op;
    assign alu_a  = ctrl.src1_is_pc ? cur_pc : rj_val;
    assign alu_b  = ctrl.is_branch ? 32'd4 : (ctrl.src2_is_imm ? imm : rkd_val);

    assign rf_we    = wb_valid;
    assign rf_waddr = ctrl.dest;
    assign rf_wdata = result_q;

    assign trace.pc    = cur_pc;
    assign trace.wnum  = ctrl.dest;
    assign trace.wdata = result_q;

    // request fields hold while req stays high.
    a_inst_stable: assert property (@(posedge clk) disable iff (reset)
        inst_req && $past(inst_req) |-> $stable(inst_addr));

    a_data_stable: assert property (@(posedge clk) disable iff (reset)
        data_req && $past(data_req) |-> $stable(data_out));

    a_one_port: assert property (@(posedge clk) disable iff (reset)
        !(inst_req && data_req));

    a_wb_state: assert property (@(posedge clk) disable iff (reset)
        wb_valid |-> state == WRITEBACK);

endmodule

`default_nettype wire

// File: source/mcycle_cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module mcycle_cpu_top import cpu_pkg::*; #(
    parameter logic [31:0] reset_pc = 32'h1c00_0000
) (
    input  logic        clk,
    input  logic        reset,
    output logic        inst_req,
    output logic [31:0] inst_addr,
    input  logic        inst_ack,
    input  logic [31:0] inst_rdata,
    output logic        data_req,
    output mem_req_t    data_out,
    input  logic        data_ack,
    input  logic [31:0] data_rdata,
    output logic        wb_valid,
    output wb_trace_t   trace
);

    logic [31:0] inst_word;
    ctrl_t       ctrl;
    logic [31:0] imm;
    logic [4:0]  raddr1;
    logic [4:0]  raddr2;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    alu_op_t     alu_op;
    logic [31:0] alu_a;
    logic [31:0] alu_b;
    logic [31:0] alu_result;
    logic        rf_we;
    logic [4:0]  rf_waddr;
    logic [31:0] rf_wdata;

    cycle_control #(
        .reset_pc (reset_pc)
    ) u_control (
        .clk        (clk),
        .reset      (reset),
        .inst_req   (inst_req),
        .inst_addr  (inst_addr),
        .inst_ack   (inst_ack),
        .inst_rdata (inst_rdata),
        .data_req   (data_req),
        .data_out   (data_out),
        .data_ack   (data_ack),
        .data_rdata (data_rdata),
        .inst_word  (inst_word),
        .ctrl       (ctrl),
        .imm        (imm),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .alu_op     (alu_op),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_result (alu_result),
        .rf_we      (rf_we),
        .rf_waddr   (rf_waddr),
        .rf_wdata   (rf_wdata),
        .wb_valid   (wb_valid),
        .trace      (trace)
    );

    inst_decoder u_decoder (
        .inst_word (inst_word),
        .ctrl      (ctrl),
        .imm       (imm),
        .raddr1    (raddr1),
        .raddr2    (raddr2)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (raddr1),
        .rdata1 (rs1_data),
        .raddr2 (raddr2),
        .rdata2 (rs2_data),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    alu u_alu (
        .op     (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result)
    );

endmodule

`default_nettype wire

// File: verification/tb_mcycle_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mcycle_cpu import cpu_pkg::*; ();

    localparam logic [31:0] reset_addr = 32'h1c00_0000;
    localparam int          timeout_cycles = 300;
    localparam logic [16:0] op_add  = 17'h00020;
    localparam logic [16:0] op_sub  = 17'h00022;
    localparam logic [16:0] op_slt  = 17'h00024;
    localparam logic [16:0] op_sltu = 17'h00025;
    localparam logic [16:0] op_nor  = 17'h00028;
    localparam logic [16:0] op_and  = 17'h00029;
    localparam logic [16:0] op_or   = 17'h0002a;
    localparam logic [16:0] op_xor  = 17'h0002b;
    localparam logic [16:0] op_slli = 17'h00081;
    localparam logic [16:0] op_srli = 17'h00089;
    localparam logic [16:0] op_srai = 17'h00091;
    localparam logic [9:0]  op_addi = 10'h00a;
    localparam logic [9:0]  op_ldw  = 10'h0a2;
    localparam logic [9:0]  op_stw  = 10'h0a6;
    localparam logic [5:0]  op_jirl = 6'h13;
    localparam logic [5:0]  op_b    = 6'h14;
    localparam logic [5:0]  op_bl   = 6'h15;
    localparam logic [5:0]  op_beq  = 6'h16;
    localparam logic [5:0]  op_bne  = 6'h17;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic        inst_req;
    logic [31:0] inst_addr;
    logic        inst_ack = 1'b0;
    logic [31:0] inst_rdata = '0;
    logic        data_req;
    mem_req_t    data_out;
    logic        data_ack = 1'b0;
    logic [31:0] data_rdata = '0;
    logic        wb_valid;
    wb_trace_t   trace;

    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:255];
    logic [31:0] ref_mem [0:255];
    logic [31:0] ref_regs [0:31];
    logic [31:0] prog [$];
    logic [31:0] exp_pc [$];
    logic [31:0] exp_num [$];
    logic [31:0] exp_val [$];
    integer      seed = 38;
    bit          random_delay = 1'b0;
    int          fixed_delay = 1;
    int          inst_wait = 0;
    int          inst_delay = 0;
    int          data_wait = 0;
    int          data_delay = 0;
    int          errors = 0;
    int          mem_errors = 0;
    int          checks = 0;

    mcycle_cpu_top #(
        .reset_pc (reset_addr)
    ) dut (
        .clk        (clk),
        .reset      (reset),
        .inst_req   (inst_req),
        .inst_addr  (inst_addr),
        .inst_ack   (inst_ack),
        .inst_rdata (inst_rdata),
        .data_req   (data_req),
        .data_out   (data_out),
        .data_ack   (data_ack),
        .data_rdata (data_rdata),
        .wb_valid   (wb_valid),
        .trace      (trace)
    );

    always #50 clk = ~clk;

    function automatic int next_delay();
        logic [31:0] r;
        if (random_delay) begin
            r = $random(seed);
            return int'(r % 32'd4);
        end
        return fixed_delay;
    endfunction

    function automatic logic [31:0] data_fill(input int idx);
        logic [31:0] a;
        a = idx * 4;
        return ~a ^ {a[15:0], a[31:16]};
    endfunction

    // opcode 0x3f never decodes so stray fetches act as no-ops.
    function automatic logic [31:0] code_fill(input int idx);
        logic [31:0] a;
        a = reset_addr + idx * 4;
        return {6'h3f, a[25:0] ^ {20'd0, a[31:26]}};
    endfunction

    function automatic logic [31:0] reg3_word(input logic [16:0] op, input int rd,
                                              input int rj, input int rk);
        return {op, rk[4:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic logic [31:0] imm12_word(input logic [9:0] op, input int rd,
                                               input int rj, input int si12);
        return {op, si12[11:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic logic [31:0] upper_word(input int rd, input int si20);
        return {7'h0a, si20[19:0], rd[4:0]};
    endfunction

    function automatic logic [31:0] off16_word(input logic [5:0] op, input int rd,
                                               input int rj, input int offs);
        return {op, offs[15:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic logic [31:0] off26_word(input logic [5:0] op, input int offs);
        return {op, offs[15:0], offs[25:16]};
    endfunction

    // instruction and data memory models.
    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 256; i++) begin
                dmem[i] = data_fill(i);
            end
            inst_wait = 0;
            data_wait = 0;
            inst_delay = next_delay();
            data_delay = next_delay();
        end
        #1;
        if (inst_ack) begin
            if (!inst_req) begin
                inst_ack = 1'b0;
                inst_delay = next_delay();
            end
        end else if (!inst_req) begin
            inst_wait = 0;
        end else if (inst_wait >= inst_delay) begin
            if (inst_addr[31:10] != reset_addr[31:10]) begin
                $display("instruction fetch outside memory at address %h", inst_addr);
                mem_errors++;
            end
            inst_ack = 1'b1;
            inst_rdata = imem[inst_addr[9:2]];
        end else begin
            inst_wait++;
        end
        if (data_ack) begin
            if (!data_req) begin
                data_ack = 1'b0;
                data_delay = next_delay();
            end
        end else if (!data_req) begin
            data_wait = 0;
        end else if (data_wait >= data_delay) begin
            if (data_out.addr[31:10] != 22'd0) begin
                $display("data access outside memory at address %h", data_out.addr);
                mem_errors++;
            end
            data_ack = 1'b1;
            // store lands as ack rises.
            if (data_out.we) begin
                dmem[data_out.addr[9:2]] = data_out.wdata;
            end else begin
                data_rdata = dmem[data_out.addr[9:2]];
            end
        end else begin
            data_wait++;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            $display("CHECK FAILED at time %0t: %s expected %h, got %h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    // instruction-level model that stops at a branch to itself.
    task automatic interpret();
        logic [31:0] pc, w, a, b, dv, val, s12, o16, o26, next_pc;
        logic [4:0]  dest;
        logic        wr;
        logic        halted;
        pc = reset_addr;
        halted = 1'b0;
        exp_pc.delete();
        exp_num.delete();
        exp_val.delete();
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        for (int step = 0; step < 200 && !halted; step++) begin
            w = prog[(pc - reset_addr) >> 2];
            a = ref_regs[w[9:5]];
            b = ref_regs[w[14:10]];
            dv = ref_regs[w[4:0]];
            s12 = {{20{w[21]}}, w[21:10]};
            o16 = {{14{w[25]}}, w[25:10], 2'b00};
            o26 = {{4{w[9]}}, w[9:0], w[25:10], 2'b00};
            dest = w[4:0];
            wr = 1'b1;
            val = '0;
            next_pc = pc + 32'd4;
            if (w[31:15] == op_add) val = a + b;
            else if (w[31:15] == op_sub) val = a - b;
            else if (w[31:15] == op_slt) val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            else if (w[31:15] == op_sltu) val = (a < b) ? 32'd1 : 32'd0;
            else if (w[31:15] == op_nor) val = ~(a | b);
            else if (w[31:15] == op_and) val = a & b;
            else if (w[31:15] == op_or) val = a | b;
            else if (w[31:15] == op_xor) val = a ^ b;
            else if (w[31:15] == op_slli) val = a << w[14:10];
            else if (w[31:15] == op_srli) val = a >> w[14:10];
            else if (w[31:15] == op_srai) val = $unsigned($signed(a) >>> w[14:10]);
            else if (w[31:22] == op_addi) val = a + s12;
            else if (w[31:22] == op_ldw) val = ref_mem[(a + s12) >> 2];
            else if (w[31:25] == 7'h0a) val = {w[24:5], 12'd0};
            else if (w[31:22] == op_stw) begin
                ref_mem[(a + s12) >> 2] = dv;
                wr = 1'b0;
            end else if (w[31:26] == op_jirl) begin
                val = pc + 32'd4;
                next_pc = a + o16;
            end else if (w[31:26] == op_b) begin
                wr = 1'b0;
                next_pc = pc + o26;
                halted = (o26 == 32'd0);
            end else if (w[31:26] == op_bl) begin
                val = pc + 32'd4;
                dest = 5'd1;
                next_pc = pc + o26;
            end else if (w[31:26] == op_beq || w[31:26] == op_bne) begin
                wr = 1'b0;
                if ((a == dv) == (w[31:26] == op_beq)) next_pc = pc + o16;
            end else begin
                wr = 1'b0;
            end
            // r0 writes still retire while the register keeps zero.
            if (wr) begin
                exp_pc.push_back(pc);
                exp_num.push_back({27'd0, dest});
                exp_val.push_back(val);
                if (dest != 5'd0) ref_regs[dest] = val;
            end
            pc = next_pc;
        end
    endtask

    task automatic run_program(input string name);
        int    waited;
        bit    got;
        string tag;
        tag = random_delay ? {name, " (random ack)"} : name;
        @(posedge clk);
        #1;
        reset = 1'b1;
        for (int i = 0; i < 256; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : code_fill(i);
            ref_mem[i] = data_fill(i);
        end
        interpret();
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int k = 0; k < exp_pc.size(); k++) begin
            waited = 0;
            got = 1'b0;
            while (!got && waited < timeout_cycles) begin
                @(posedge clk);
                #1;
                if (wb_valid) got = 1'b1;
                else waited++;
            end
            if (!got) begin
                $display("%s: timeout, write %0d to r%0d from pc %h never arrived",
                         tag, k, exp_num[k], exp_pc[k]);
                errors++;
                break;
            end
            check_value("trace.pc", exp_pc[k], trace.pc);
            check_value("trace.wnum", exp_num[k], {27'd0, trace.wnum});
            check_value("trace.wdata", exp_val[k], trace.wdata);
        end
        repeat (40) begin
            @(posedge clk);
            #1;
            if (wb_valid) begin
                $display("%s: unexpected register write to r%0d from pc %h",
                         tag, trace.wnum, trace.pc);
                errors++;
            end
        end
        for (int i = 0; i < 256; i++) begin
            check_value($sformatf("dmem[%h]", i * 4), ref_mem[i], dmem[i]);
        end
        $display("%s: %0d register writes compared", tag, exp_pc.size());
    endtask

    task automatic arith_test();
        prog.delete();
        prog.push_back(imm12_word(op_addi, 4, 0, -5));
        prog.push_back(imm12_word(op_addi, 5, 0, 3));
        prog.push_back(reg3_word(op_add, 6, 4, 5));
        prog.push_back(reg3_word(op_sub, 7, 5, 4));
        prog.push_back(reg3_word(op_slt, 8, 4, 5));
        prog.push_back(reg3_word(op_sltu, 9, 4, 5));
        prog.push_back(reg3_word(op_nor, 10, 4, 5));
        prog.push_back(reg3_word(op_and, 11, 4, 5));
        prog.push_back(reg3_word(op_or, 12, 4, 5));
        prog.push_back(reg3_word(op_xor, 13, 4, 5));
        prog.push_back(off26_word(op_b, 0));
        run_program("arith");
    endtask

    task automatic imm_shift_test();
        prog.delete();
        prog.push_back(upper_word(4, 32'h80001));
        prog.push_back(imm12_word(op_addi, 4, 4, 32'h234));
        prog.push_back(imm12_word(op_addi, 5, 4, -1));
        prog.push_back(reg3_word(op_slli, 6, 4, 3));
        prog.push_back(reg3_word(op_srli, 7, 4, 4));
        prog.push_back(reg3_word(op_srai, 8, 4, 4));
        prog.push_back(reg3_word(op_srai, 9, 4, 31));
        prog.push_back(upper_word(10, 32'h12345));
        prog.push_back(off26_word(op_b, 0));
        run_program("imm_shift");
    endtask

    task automatic memory_test();
        prog.delete();
        prog.push_back(imm12_word(op_addi, 4, 0, 32'h100));
        prog.push_back(upper_word(5, 32'hcafe1));
        prog.push_back(imm12_word(op_addi, 6, 0, -77));
        prog.push_back(imm12_word(op_stw, 5, 4, 0));
        prog.push_back(imm12_word(op_stw, 6, 4, 8));
        prog.push_back(imm12_word(op_stw, 4, 4, -4));
        prog.push_back(imm12_word(op_ldw, 7, 4, 8));
        prog.push_back(imm12_word(op_ldw, 8, 4, 0));
        prog.push_back(imm12_word(op_ldw, 9, 4, -4));
        prog.push_back(imm12_word(op_ldw, 10, 4, 16));
        prog.push_back(off26_word(op_b, 0));
        run_program("memory");
    endtask

    // skipped slots write r7, r9, r11, r12, r13 and r16.
    task automatic branch_test();
        prog.delete();
        prog.push_back(imm12_word(op_addi, 4, 0, 7));
        prog.push_back(imm12_word(op_addi, 5, 0, 7));
        prog.push_back(imm12_word(op_addi, 6, 0, 9));
        prog.push_back(off16_word(op_beq, 5, 4, 2));
        prog.push_back(imm12_word(op_addi, 7, 0, 1));
        prog.push_back(off16_word(op_beq, 6, 4, 2));
        prog.push_back(imm12_word(op_addi, 8, 0, 2));
        prog.push_back(off16_word(op_bne, 6, 4, 2));
        prog.push_back(imm12_word(op_addi, 9, 0, 3));
        prog.push_back(off16_word(op_bne, 5, 4, 2));
        prog.push_back(imm12_word(op_addi, 10, 0, 4));
        prog.push_back(off26_word(op_b, 2));
        prog.push_back(imm12_word(op_addi, 11, 0, 5));
        prog.push_back(off26_word(op_bl, 3));
        prog.push_back(imm12_word(op_addi, 12, 0, 6));
        prog.push_back(imm12_word(op_addi, 13, 0, 7));
        prog.push_back(imm12_word(op_addi, 14, 1, 12));
        prog.push_back(off16_word(op_jirl, 15, 14, 2));
        prog.push_back(imm12_word(op_addi, 16, 0, 8));
        prog.push_back(imm12_word(op_addi, 17, 15, 0));
        prog.push_back(off26_word(op_b, 0));
        run_program("branch");
    endtask

    task automatic r0_test();
        prog.delete();
        prog.push_back(imm12_word(op_addi, 0, 0, 55));
        prog.push_back(reg3_word(op_add, 4, 0, 0));
        prog.push_back(imm12_word(op_addi, 5, 0, 9));
        prog.push_back(reg3_word(op_add, 0, 5, 5));
        prog.push_back(reg3_word(op_sub, 6, 5, 0));
        prog.push_back(reg3_word(op_or, 7, 0, 5));
        prog.push_back(off26_word(op_b, 0));
        run_program("r0");
    endtask

    task automatic rerun_with_random_delays();
        random_delay = 1'b1;
        arith_test();
        imm_shift_test();
        memory_test();
        branch_test();
    endtask

    initial begin
        arith_test();
        imm_shift_test();
        memory_test();
        branch_test();
        r0_test();
        rerun_with_random_delays();
        $display("run complete: %0d checks, %0d errors", checks, errors + mem_errors);
        if (errors + mem_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
source/cpu_pkg.sv
source/inst_decoder.sv
source/regfile.sv
source/alu.sv
source/cycle_control.sv
source/mcycle_cpu_top.sv
verification/tb_mcycle_cpu.sv

// File: run_sim.sh
#!/bin/sh
# build with verilator, run into sim.log, then look for the pass line.

cd "$(dirname "$0")" || exit 1
log=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/1ps -f flist.f \
        --top-module tb_mcycle_cpu -o tb_mcycle_cpu; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/tb_mcycle_cpu > "$log" 2>&1; then
    cat "$log"
    echo "simulation exited with an error"
    exit 1
fi

cat "$log"
if grep -q "^PASS: all tests$" "$log"; then
    exit 0
fi
echo "pass line not found in $log"
exit 1
